/* dv/flash_model.sv */
// Behavioral SPI flash for the testbench, mode 0, read command only.
// After 32 command and address bits it answers with a word derived from the address.
`timescale 1ns/1ns

module flash_model (
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  logic [31:0] cmd_q;
  logic [31:0] word_q;
  int          bit_cnt;

  // word address times four, xor a fixed tag
  function automatic logic [31:0] answer_word(input logic [31:0] cmd);
    if (cmd[31:24] != 8'h03) begin
      return 32'h0;
    end
    return ({8'h00, cmd[23:0]} << 2) ^ 32'hA5A5_0000;
  endfunction

  initial begin
    miso_o  = 1'b0;
    cmd_q   = '0;
    word_q  = '0;
    bit_cnt = 0;
  end

  // deselect ends the frame
  always @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      bit_cnt = 0;
    end else begin
      if (bit_cnt < 32) begin
        cmd_q = {cmd_q[30:0], mosi_i};
      end
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 32) begin
        word_q = answer_word(cmd_q);
      end
    end
  end

  // data goes out MSB first on falling sck
  always @(negedge sck_i) begin
    if (!ss_n_i && bit_cnt >= 32 && bit_cnt < 64) begin
      miso_o = word_q[63 - bit_cnt];
    end
  end

endmodule

/* dv/spi_top_apb_tb.sv */
// Testbench for the SPI flash controller with a flash model on slave select 0.
// Runs XIP reads, register accesses and manual transfers over the host APB port.
`timescale 1ns/1ns

module spi_top_apb_tb
  import spi_reg_pkg::*;
();

  localparam logic [19:0] spi_base   = 20'h10001;
  localparam int          ss_num     = 8;
  localparam int          xip_reads  = 20;
  // 64 two-clock bits per read, times three for bus overhead and the manual transfers
  localparam int unsigned timeout_ns = xip_reads * 64 * 2 * 8 * 3 + 2000;
  localparam int          irq_limit  = 1000;

  logic              clock;
  logic              reset;
  logic [31:0]       paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic              pready;
  logic [31:0]       prdata;
  logic              pslverr;
  logic              sck;
  logic [ss_num-1:0] ss;
  logic              mosi;
  logic              miso;
  logic              irq;
  int                errors = 0;
  int                seed = 42725;

  spi_top_apb #(
    .spi_base(spi_base), .flash_base(4'h3), .ss_num(ss_num), .clk_div(16'd0)
  ) spi_top_apb_i (
    .clock(clock), .reset(reset),
    .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .pwdata_i(pwdata), .pready_o(pready), .prdata_o(prdata), .pslverr_o(pslverr),
    .sck_o(sck), .ss_o(ss), .mosi_o(mosi), .miso_i(miso), .irq_o(irq)
  );

  flash_model u_flash (.sck_i(sck), .ss_n_i(ss[0]), .mosi_i(mosi), .miso_o(miso));

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    #(timeout_ns);
    $display("timeout, the tests did not finish in time");
    $display("Errors found");
    $finish;
  end

  // error answers always come with pready
  assert property (@(posedge clock) disable iff (reset) pslverr |-> pready)
    else begin
      errors++;
      $display("pslverr_o was high without pready_o");
    end

  assert property (@(posedge clock) disable iff (reset) sck |-> !ss[0])
    else begin
      errors++;
      $display("sck_o toggled while the flash was not selected");
    end

  function automatic logic [31:0] reg_addr(input logic [2:0] offs);
    return {spi_base, 7'd0, offs, 2'b00};
  endfunction

  // 24-bit word address with the low two bits cleared
  function automatic logic [31:0] flash_word(input logic [31:0] addr);
    return ({8'h00, addr[23:2], 2'b00} << 2) ^ 32'hA5A5_0000;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else begin
        errors++;
        $display("Error %s: expected %h, actual %h", name, expected, actual);
      end
  endtask

  task automatic apb_access(input logic [31:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clock);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clock);
    penable <= 1'b1;
    @(posedge clock);
    while (!pready) @(posedge clock);
    rdata = prdata;
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic manual_transfer(input logic [23:0] addr, input bit busy_write);
    logic [31:0] ctrl_word;
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    ctrl_word = (32'd1 << ctrl_go_bit) | (32'd1 << ctrl_ie_bit)
              | (32'd1 << ctrl_ass_bit) | 32'd64;
    apb_access(reg_addr(tx_0_offs), 1'b1, 32'h1234_5678, rdata, err);
    apb_access(reg_addr(tx_1_offs), 1'b1, {8'h03, addr}, rdata, err);
    apb_access(reg_addr(ctrl_offs), 1'b1, ctrl_word, rdata, err);
    if (busy_write) begin
      apb_access(reg_addr(tx_0_offs), 1'b1, 32'hDEAD_BEEF, rdata, err);
      check_value("busy_tx_pslverr", 32'd1, 32'(err));
      apb_access(reg_addr(rx_0_offs), 1'b0, 32'd0, rdata, err);
      check_value("busy_tx_kept", 32'h1234_5678, rdata);
    end
    cycles = 0;
    while (!irq && cycles < irq_limit) begin
      @(posedge clock);
      cycles++;
    end
    assert (irq)
      else begin
        errors++;
        $display("irq_o did not rise after the manual transfer");
      end
    apb_access(reg_addr(ctrl_offs), 1'b0, 32'd0, rdata, err);
    check_value("ctrl_go_clear", ctrl_word & ~(32'd1 << ctrl_go_bit), rdata);
    @(posedge clock);
    check_value("irq_clear", 32'd0, 32'(irq));
    apb_access(reg_addr(rx_0_offs), 1'b0, 32'd0, rdata, err);
    check_value("manual_rx", flash_word({8'h00, addr}), rdata);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
    reset   = 1'b1;
    paddr   = 32'd0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = 32'd0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    check_value("reset_pready", 32'd0, 32'(pready));
    check_value("reset_irq", 32'd0, 32'(irq));
    check_value("reset_sck", 32'd0, 32'(sck));
    check_value("reset_ss", 32'hFF, 32'(ss));
    check_value("reset_mosi", 32'd1, 32'(mosi));

    for (int i = 0; i < xip_reads; i++) begin
      rnd  = $random(seed);
      addr = {4'h3, rnd[27:2], 2'b00};
      apb_access(addr, 1'b0, 32'd0, rdata, err);
      check_value("xip_read", flash_word(addr), rdata);
      check_value("xip_pslverr", 32'd0, 32'(err));
    end

    apb_access(reg_addr(divider_offs), 1'b1, 32'h0000_0005, rdata, err);
    apb_access(reg_addr(divider_offs), 1'b0, 32'd0, rdata, err);
    check_value("divider", 32'h0000_0005, rdata);
    apb_access(reg_addr(divider_offs), 1'b1, 32'd0, rdata, err);
    apb_access(reg_addr(tx_0_offs), 1'b1, 32'hC3A5_5A3C, rdata, err);
    apb_access(reg_addr(rx_0_offs), 1'b0, 32'd0, rdata, err);
    check_value("tx_0", 32'hC3A5_5A3C, rdata);

    rnd = $random(seed);
    manual_transfer({rnd[23:2], 2'b00}, 1'b0);

    apb_access(32'h3000_0010, 1'b1, 32'h5555_AAAA, rdata, err);
    check_value("flash_write_pslverr", 32'd1, 32'(err));
    apb_access(reg_addr(3'd7), 1'b0, 32'd0, rdata, err);
    check_value("unmapped_pslverr", 32'd1, 32'(err));

    rnd = $random(seed);
    manual_transfer({rnd[23:2], 2'b00}, 1'b1);

    repeat (4) @(posedge clock);
    $display("error count: %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* project.f */
verilog/spi_reg_pkg.sv
verilog/flash_xip_pkg.sv
verilog/apb_spi_decode.sv
verilog/flash_xip_seq.sv
verilog/spi_regs.sv
verilog/spi_shifter.sv
verilog/spi_top_apb.sv
dv/flash_model.sv
dv/spi_top_apb_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the SPI flash controller testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module spi_top_apb_tb -o spi_top_apb_sim &&
  ./obj_dir/spi_top_apb_sim | tee /dev/stderr | grep -x "No errors" > /dev/null &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* verilog/apb_spi_decode.sv */
// Host address decode and register bus arbitration.
// Register window goes to spi_regs, flash reads go to the XIP sequencer.
`timescale 1ns/1ns

module apb_spi_decode
  import spi_reg_pkg::*;
#(
  parameter logic [19:0] spi_base   = 20'h10001,
  parameter logic [3:0]  flash_base = 4'h3
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  output logic        pready_o,
  output logic [31:0] prdata_o,
  output logic        pslverr_o,
  output logic        xip_req_o,
  input  logic        xip_ready_i,
  input  logic [31:0] xip_rdata_i,
  input  logic        seq_busy_i,
  input  reg_sel_e    seq_sel_i,
  input  logic        seq_psel_i,
  input  logic        seq_penable_i,
  input  logic        seq_pwrite_i,
  input  logic [31:0] seq_pwdata_i,
  output reg_sel_e    reg_sel_o,
  output logic        reg_psel_o,
  output logic        reg_penable_o,
  output logic        reg_pwrite_o,
  output logic [31:0] reg_pwdata_o,
  input  logic        reg_pready_i,
  input  logic [31:0] reg_prdata_i,
  input  logic        reg_pslverr_i,
  output logic        seq_pready_o,
  output logic [31:0] seq_prdata_o
);

  logic       spi_hit;
  logic       flash_hit;
  logic       host_reg;
  logic       bad;
  logic       err_q;
  logic [2:0] offs;
  reg_sel_e   host_sel;

  assign spi_hit   = (paddr_i[31:12] == spi_base);
  assign flash_hit = (paddr_i[31:28] == flash_base);
  assign offs      = paddr_i[4:2];

  // offset 0 and 1 hold rx on reads, tx on writes
  always_comb begin
    host_sel = sel_none;
    if (paddr_i[11:5] == 7'd0) begin
      if (pwrite_i && offs == tx_0_offs) host_sel = sel_tx_0;
      else if (pwrite_i && offs == tx_1_offs) host_sel = sel_tx_1;
      else if (offs == rx_0_offs) host_sel = sel_rx_0;
      else if (offs == rx_1_offs) host_sel = sel_rx_1;
      else if (offs == ctrl_offs) host_sel = sel_ctrl;
      else if (offs == divider_offs) host_sel = sel_divider;
      else if (offs == ss_offs) host_sel = sel_ss;
    end
  end

  assign host_reg  = spi_hit && (host_sel != sel_none);
  assign xip_req_o = psel_i && penable_i && flash_hit && !pwrite_i;
  // flash writes and holes in the map
  assign bad       = psel_i && penable_i && !host_reg && !xip_req_o;

  // error answer in the second access cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bad && !err_q;
    end
  end

  always_comb begin
    pready_o  = 1'b0;
    prdata_o  = 32'd0;
    pslverr_o = 1'b0;
    if (err_q) begin
      pready_o  = 1'b1;
      pslverr_o = 1'b1;
    end else if (host_reg) begin
      // host waits while the sequencer owns the bus
      if (!seq_busy_i) begin
        pready_o  = reg_pready_i;
        prdata_o  = reg_prdata_i;
        pslverr_o = reg_pslverr_i;
      end
    end else if (xip_req_o) begin
      pready_o = xip_ready_i;
      prdata_o = xip_rdata_i;
    end
  end

  assign reg_sel_o     = seq_busy_i ? seq_sel_i : host_sel;
  assign reg_psel_o    = seq_busy_i ? seq_psel_i : (psel_i && host_reg);
  assign reg_penable_o = seq_busy_i ? seq_penable_i : (penable_i && host_reg);
  assign reg_pwrite_o  = seq_busy_i ? seq_pwrite_i : pwrite_i;
  assign reg_pwdata_o  = seq_busy_i ? seq_pwdata_i : pwdata_i;

  assign seq_pready_o = seq_busy_i && reg_pready_i;
  assign seq_prdata_o = reg_prdata_i;

endmodule

/* verilog/flash_xip_pkg.sv */
// Flash command set and XIP sequencer states.
// Imported by the sequencer, which is the only block that speaks to the flash.
package flash_xip_pkg;

  // standard serial flash opcodes
  typedef enum logic [7:0] {
    flash_read = 8'h03
  } flash_cmd_e;

  // init_* run once after reset, the rest serve one XIP read each
  typedef enum logic [2:0] {
    init_div,
    init_ss,
    init_ctrl,
    idle,
    write_cmd,
    start_trans,
    wait_trans,
    read_data
  } xip_state_e;

endpackage

/* verilog/flash_xip_seq.sv */
// XIP sequencer, a second bus master on the SPI register block.
// Programs the master after reset, then turns each flash read request into one SPI transfer.
`timescale 1ns/1ns

module flash_xip_seq
  import spi_reg_pkg::*;
  import flash_xip_pkg::*;
#(
  parameter logic [15:0] clk_div = 16'd0
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        xip_req_i,
  input  logic [23:0] xip_addr_i,
  output logic        xip_ready_o,
  output logic [31:0] xip_rdata_o,
  output logic        busy_o,
  output reg_sel_e    seq_sel_o,
  output logic        psel_o,
  output logic        penable_o,
  output logic        pwrite_o,
  output logic [31:0] pwdata_o,
  input  logic        pready_i,
  input  logic [31:0] prdata_i,
  input  logic        irq_i
);

  // 64-bit frame, auto slave select, irq on done, tx on falling sck
  localparam logic [31:0] ctrl_cfg = (32'd1 << ctrl_ass_bit)
                                   | (32'd1 << ctrl_ie_bit)
                                   | (32'd1 << ctrl_tx_neg_bit)
                                   | (32'd64 << ctrl_char_len_lsb);
  localparam logic [31:0] ctrl_go  = ctrl_cfg | (32'd1 << ctrl_go_bit);

  xip_state_e  state;
  logic        acc_q;
  logic        step;
  logic [23:0] addr_q;

  // current bus access finishes this cycle
  assign step      = acc_q && pready_i;
  assign busy_o    = (state != idle);
  assign psel_o    = busy_o && (state != wait_trans);
  assign penable_o = acc_q;
  assign pwrite_o  = (state != read_data);

  always_comb begin
    seq_sel_o = sel_none;
    pwdata_o  = 32'd0;
    case (state)
      init_div: begin
        seq_sel_o = sel_divider;
        pwdata_o  = {16'd0, clk_div};
      end
      init_ss: begin
        seq_sel_o = sel_ss;
        pwdata_o  = 32'd1;
      end
      init_ctrl: begin
        seq_sel_o = sel_ctrl;
        pwdata_o  = ctrl_cfg;
      end
      write_cmd: begin
        seq_sel_o = sel_tx_1;
        pwdata_o  = {flash_read, addr_q};
      end
      start_trans: begin
        seq_sel_o = sel_ctrl;
        pwdata_o  = ctrl_go;
      end
      read_data: begin
        seq_sel_o = sel_rx_0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= init_div;
      acc_q       <= 1'b0;
      xip_ready_o <= 1'b0;
    end else begin
      xip_ready_o <= 1'b0;
      // setup phase, then access phase until pready
      acc_q <= psel_o && !step;
      case (state)
        init_div: begin
          if (step) state <= init_ss;
        end
        init_ss: begin
          if (step) state <= init_ctrl;
        end
        init_ctrl: begin
          if (step) state <= idle;
        end
        idle: begin
          // request is still held in the cycle of our own ready
          if (xip_req_i && !xip_ready_o) state <= write_cmd;
        end
        write_cmd: begin
          if (step) state <= start_trans;
        end
        start_trans: begin
          if (step) state <= wait_trans;
        end
        wait_trans: begin
          if (irq_i) state <= read_data;
        end
        read_data: begin
          if (step) begin
            state       <= idle;
            xip_ready_o <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == idle && xip_req_i) addr_q <= xip_addr_i;
    if (state == read_data && step) xip_rdata_o <= prdata_i;
  end

endmodule

/* verilog/spi_reg_pkg.sv */
// SPI master register map shared by the decoder, the XIP sequencer and the register block.
// Offsets are word indices into the 32-byte register window.
package spi_reg_pkg;

  // word offsets, rx and tx share a location
  localparam logic [2:0] rx_0_offs    = 3'd0;
  localparam logic [2:0] rx_1_offs    = 3'd1;
  localparam logic [2:0] tx_0_offs    = 3'd0;
  localparam logic [2:0] tx_1_offs    = 3'd1;
  localparam logic [2:0] ctrl_offs    = 3'd4;
  localparam logic [2:0] divider_offs = 3'd5;
  localparam logic [2:0] ss_offs      = 3'd6;

  // ctrl fields, char_len of 0 means 128 bits
  localparam int unsigned ctrl_char_len_lsb = 0;
  localparam int unsigned ctrl_char_len_w   = 7;
  localparam int unsigned ctrl_go_bit       = 8;
  localparam int unsigned ctrl_rx_neg_bit   = 9;
  localparam int unsigned ctrl_tx_neg_bit   = 10;
  localparam int unsigned ctrl_lsb_bit      = 11;
  localparam int unsigned ctrl_ie_bit       = 12;
  localparam int unsigned ctrl_ass_bit      = 13;

  typedef enum logic [2:0] {
    sel_rx_0, sel_rx_1, sel_tx_0, sel_tx_1,
    sel_ctrl, sel_divider, sel_ss, sel_none
  } reg_sel_e;

endpackage

/* verilog/spi_regs.sv */
// SPI master register file on an APB-style bus with one wait state.
// Holds divider, slave select, ctrl and the shared tx/rx data register.
`timescale 1ns/1ns

module spi_regs
  import spi_reg_pkg::*;
#(
  parameter int ss_num = 8
) (
  input  logic              clock,
  input  logic              reset,
  input  reg_sel_e          reg_sel_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  output logic              pready_o,
  output logic [31:0]       prdata_o,
  output logic              pslverr_o,
  output logic              irq_o,
  output logic              go_o,
  output logic [6:0]        char_len_o,
  output logic              lsb_o,
  output logic [15:0]       divider_o,
  output logic [ss_num-1:0] ss_o,
  output logic [127:0]      tx_data_o,
  input  logic [127:0]      rx_data_i,
  input  logic              done_i,
  input  logic              busy_i
);

  localparam int unsigned ctrl_w = ctrl_ass_bit + 1;
  localparam logic [ctrl_w-1:0] ctrl_mask =
    ctrl_w'(((32'd1 << ctrl_char_len_w) - 32'd1) << ctrl_char_len_lsb)
    | (ctrl_w'(1) << ctrl_go_bit) | (ctrl_w'(1) << ctrl_rx_neg_bit)
    | (ctrl_w'(1) << ctrl_tx_neg_bit) | (ctrl_w'(1) << ctrl_lsb_bit)
    | (ctrl_w'(1) << ctrl_ie_bit) | (ctrl_w'(1) << ctrl_ass_bit);

  logic              ack_q;
  logic [ctrl_w-1:0] ctrl_q;
  logic [ss_num-1:0] ss_q;
  logic [127:0]      data_q;
  logic              access;
  logic              blocked;
  logic              wr_en;
  logic              rd_en;

  assign access  = psel_i && penable_i && ack_q;
  // data and ctrl are frozen during a transfer
  assign blocked = pwrite_i && busy_i && (reg_sel_i inside {sel_tx_0, sel_tx_1, sel_ctrl});
  assign wr_en   = access && pwrite_i && !blocked;
  assign rd_en   = access && !pwrite_i;

  assign pready_o  = ack_q;
  assign pslverr_o = ack_q && (blocked || reg_sel_i == sel_none);

  always_ff @(posedge clock) begin
    if (reset) begin
      ack_q     <= 1'b0;
      ctrl_q    <= '0;
      divider_o <= 16'd0;
      ss_q      <= '0;
      irq_o     <= 1'b0;
    end else begin
      ack_q <= psel_i && penable_i && !ack_q;
      if (done_i) ctrl_q[ctrl_go_bit] <= 1'b0;
      if (rd_en && (reg_sel_i inside {sel_ctrl, sel_rx_0})) irq_o <= 1'b0;
      if (done_i && ctrl_q[ctrl_ie_bit]) irq_o <= 1'b1;
      if (wr_en) begin
        case (reg_sel_i)
          sel_ctrl: begin
            ctrl_q <= pwdata_i[ctrl_w-1:0] & ctrl_mask;
            // a new transfer drops any stale irq
            if (pwdata_i[ctrl_go_bit]) irq_o <= 1'b0;
          end
          sel_divider: divider_o <= pwdata_i[15:0];
          sel_ss:      ss_q <= pwdata_i[ss_num-1:0];
          default: ;
        endcase
      end
    end
  end

  // received bits replace the transmitted ones
  always_ff @(posedge clock) begin
    if (done_i) data_q <= rx_data_i;
    else if (wr_en && reg_sel_i == sel_tx_0) data_q[31:0] <= pwdata_i;
    else if (wr_en && reg_sel_i == sel_tx_1) data_q[63:32] <= pwdata_i;
  end

  always_comb begin
    case (reg_sel_i)
      sel_rx_0, sel_tx_0: prdata_o = data_q[31:0];
      sel_rx_1, sel_tx_1: prdata_o = data_q[63:32];
      sel_ctrl:           prdata_o = 32'(ctrl_q);
      sel_divider:        prdata_o = {16'd0, divider_o};
      sel_ss:             prdata_o = 32'(ss_q);
      default:            prdata_o = 32'd0;
    endcase
  end

  assign go_o       = ctrl_q[ctrl_go_bit];
  assign char_len_o = ctrl_q[ctrl_char_len_lsb +: ctrl_char_len_w];
  assign lsb_o      = ctrl_q[ctrl_lsb_bit];
  assign tx_data_o  = data_q;

  // with ass, select only while shifting; pads are active low
  assign ss_o = (ctrl_q[ctrl_ass_bit] && !busy_i) ? '1 : ~ss_q;

endmodule

/* verilog/spi_shifter.sv */
// SPI clock generator and shift engine, mode 0 timing.
// mosi changes on falling sck, miso is sampled on rising sck.
`timescale 1ns/1ns

module spi_shifter (
  input  logic         clock,
  input  logic         reset,
  input  logic         go_i,
  input  logic [6:0]   char_len_i,
  input  logic         lsb_i,
  input  logic [15:0]  divider_i,
  input  logic [127:0] tx_data_i,
  output logic         busy_o,
  output logic         done_o,
  output logic [127:0] rx_data_o,
  output logic         sck_o,
  output logic         mosi_o,
  input  logic         miso_i
);

  logic [15:0] div_cnt;
  logic [7:0]  bit_cnt;
  logic [7:0]  len;
  logic        last_q;
  logic        tick;
  logic        rise;

  // bit k of the frame sits at k or len-1-k
  function automatic logic [6:0] bit_pos(input logic [7:0] n, input logic [7:0] k,
                                         input logic lsb);
    logic [7:0] pos;
    pos = lsb ? k : (n - 8'd1 - k);
    return pos[6:0];
  endfunction

  assign len  = (char_len_i == 7'd0) ? 8'd128 : {1'b0, char_len_i};
  assign tick = busy_o && !last_q && (div_cnt == divider_i);
  assign rise = tick && !sck_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_o  <= 1'b0;
      done_o  <= 1'b0;
      last_q  <= 1'b0;
      sck_o   <= 1'b0;
      mosi_o  <= 1'b1;
      div_cnt <= 16'd0;
      bit_cnt <= 8'd0;
    end else begin
      done_o <= 1'b0;
      if (!busy_o) begin
        if (go_i) begin
          // first bit goes out before the first rising edge
          busy_o  <= 1'b1;
          div_cnt <= 16'd0;
          bit_cnt <= 8'd0;
          mosi_o  <= tx_data_i[bit_pos(len, 8'd0, lsb_i)];
        end
      end else if (last_q) begin
        busy_o <= 1'b0;
        last_q <= 1'b0;
        sck_o  <= 1'b0;
        mosi_o <= 1'b1;
      end else if (tick) begin
        div_cnt <= 16'd0;
        sck_o   <= ~sck_o;
        if (rise) begin
          bit_cnt <= bit_cnt + 8'd1;
          if (bit_cnt == len - 8'd1) begin
            last_q <= 1'b1;
            done_o <= 1'b1;
          end
        end else begin
          mosi_o <= tx_data_i[bit_pos(len, bit_cnt, lsb_i)];
        end
      end else begin
        div_cnt <= div_cnt + 16'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!busy_o && go_i) rx_data_o <= '0;
    else if (rise) rx_data_o[bit_pos(len, bit_cnt, lsb_i)] <= miso_i;
  end

endmodule

/* verilog/spi_top_apb.sv */
// SPI flash controller behind an APB slave port.
// Register window reaches the SPI master, flash window reads run through the XIP sequencer.
`timescale 1ns/1ns

module spi_top_apb
  import spi_reg_pkg::*;
#(
  parameter logic [19:0] spi_base   = 20'h10001,
  parameter logic [3:0]  flash_base = 4'h3,
  parameter int          ss_num     = 8,
  parameter logic [15:0] clk_div    = 16'd0
) (
  input  logic              clock,
  input  logic              reset,
  input  logic [31:0]       paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  output logic              pready_o,
  output logic [31:0]       prdata_o,
  output logic              pslverr_o,
  output logic              sck_o,
  output logic [ss_num-1:0] ss_o,
  output logic              mosi_o,
  input  logic              miso_i,
  output logic              irq_o
);

  logic         xip_req, xip_ready, seq_busy;
  logic [31:0]  xip_rdata;
  reg_sel_e     seq_sel, reg_sel;
  logic         seq_psel, seq_penable, seq_pwrite, seq_pready;
  logic [31:0]  seq_pwdata, seq_prdata;
  logic         reg_psel, reg_penable, reg_pwrite, reg_pready, reg_pslverr;
  logic [31:0]  reg_pwdata, reg_prdata;
  logic         go, lsb, busy, done;
  logic [6:0]   char_len;
  logic [15:0]  divider;
  logic [127:0] tx_data, rx_data;

  apb_spi_decode #(.spi_base(spi_base), .flash_base(flash_base)) u_decode (
    .clock(clock), .reset(reset),
    .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
    .pwrite_i(pwrite_i), .pwdata_i(pwdata_i),
    .pready_o(pready_o), .prdata_o(prdata_o), .pslverr_o(pslverr_o),
    .xip_req_o(xip_req), .xip_ready_i(xip_ready), .xip_rdata_i(xip_rdata),
    .seq_busy_i(seq_busy), .seq_sel_i(seq_sel), .seq_psel_i(seq_psel),
    .seq_penable_i(seq_penable), .seq_pwrite_i(seq_pwrite), .seq_pwdata_i(seq_pwdata),
    .reg_sel_o(reg_sel), .reg_psel_o(reg_psel), .reg_penable_o(reg_penable),
    .reg_pwrite_o(reg_pwrite), .reg_pwdata_o(reg_pwdata),
    .reg_pready_i(reg_pready), .reg_prdata_i(reg_prdata), .reg_pslverr_i(reg_pslverr),
    .seq_pready_o(seq_pready), .seq_prdata_o(seq_prdata)
  );

  // 24-bit word address for the flash
  flash_xip_seq #(.clk_div(clk_div)) u_seq (
    .clock(clock), .reset(reset),
    .xip_req_i(xip_req), .xip_addr_i({paddr_i[23:2], 2'b00}),
    .xip_ready_o(xip_ready), .xip_rdata_o(xip_rdata), .busy_o(seq_busy),
    .seq_sel_o(seq_sel), .psel_o(seq_psel), .penable_o(seq_penable),
    .pwrite_o(seq_pwrite), .pwdata_o(seq_pwdata),
    .pready_i(seq_pready), .prdata_i(seq_prdata), .irq_i(irq_o)
  );

  spi_regs #(.ss_num(ss_num)) u_regs (
    .clock(clock), .reset(reset),
    .reg_sel_i(reg_sel), .psel_i(reg_psel), .penable_i(reg_penable),
    .pwrite_i(reg_pwrite), .pwdata_i(reg_pwdata),
    .pready_o(reg_pready), .prdata_o(reg_prdata), .pslverr_o(reg_pslverr),
    .irq_o(irq_o), .go_o(go), .char_len_o(char_len), .lsb_o(lsb),
    .divider_o(divider), .ss_o(ss_o), .tx_data_o(tx_data), .rx_data_i(rx_data),
    .done_i(done), .busy_i(busy)
  );

  spi_shifter u_shifter (
    .clock(clock), .reset(reset),
    .go_i(go), .char_len_i(char_len), .lsb_i(lsb), .divider_i(divider),
    .tx_data_i(tx_data), .busy_o(busy), .done_o(done), .rx_data_o(rx_data),
    .sck_o(sck_o), .mosi_o(mosi_o), .miso_i(miso_i)
  );

endmodule
